// ==== verilog/exu_pkg.sv ====
// Shared widths and operation encodings for the RV32 integer execute stage.
// Only the base integer ops, branches and the M-extension multiplies exist here.
`default_nettype none

package exu_pkg;

    localparam int XLEN        = 32;
    localparam int SHAMT_W     = $clog2(XLEN);
    localparam int MUL_ITERS   = 32;
    localparam int MUL_CNT_W   = $clog2(MUL_ITERS + 1);
    localparam int LINK_OFFSET = 4;

    typedef logic [XLEN-1:0] reg_data_t;
    typedef logic [XLEN-1:0] inst_addr_t;
    typedef logic [4:0]      reg_addr_t;

    // raw op field from decode, meaning depends on the group
    typedef logic [3:0]      dec_op_t;

    typedef enum logic [1:0] {
        GRP_NONE,
        GRP_ALU,
        GRP_BJP,
        GRP_MUL
    } grp_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI,
        ALU_AUIPC,
        ALU_LINK
    } alu_op_e;

    typedef enum logic [2:0] {
        BJP_JAL,
        BJP_JALR,
        BJP_BEQ,
        BJP_BNE,
        BJP_BLT,
        BJP_BGE,
        BJP_BLTU,
        BJP_BGEU
    } bjp_op_e;

    typedef enum logic [1:0] {
        MUL_MUL,
        MUL_MULH,
        MUL_MULHSU,
        MUL_MULHU
    } mul_op_e;

endpackage

`default_nettype wire

// ==== verilog/exu_op_if.sv ====
// One request from dispatch to an execute unit; req is a single-cycle level.
// op_t selects the unit's operation enum.
`timescale 1ns/1ps
`default_nettype none

interface exu_op_if #(
    parameter type op_t = logic
) ();
    import exu_pkg::*;

    logic      req;
    op_t       op;
    reg_data_t op1;
    reg_data_t op2;
    reg_addr_t rd;

    modport dispatch (output req, op, op1, op2, rd);
    modport unit     (input  req, op, op1, op2, rd);

endinterface

`default_nettype wire

// ==== verilog/exu_dispatch.sv ====
// Routes one decoded instruction to its execute unit, nothing while hold is high.
// jal/jalr raise both a branch request and an ALU link request.
`timescale 1ns/1ps
`default_nettype none

module exu_dispatch (
    input  logic                dec_valid_i,
    input  exu_pkg::grp_e       grp_i,
    input  exu_pkg::dec_op_t    op_i,
    input  logic                op2_imm_i,
    input  exu_pkg::inst_addr_t pc_i,
    input  exu_pkg::reg_data_t  imm_i,
    input  exu_pkg::reg_data_t  rs1_data_i,
    input  exu_pkg::reg_data_t  rs2_data_i,
    input  exu_pkg::reg_addr_t  rd_i,
    input  logic                hold_i,
    exu_op_if.dispatch          alu_o,
    exu_op_if.dispatch          bjp_o,
    exu_op_if.dispatch          mul_o
);
    import exu_pkg::*;

    logic    accept;
    logic    is_jump;
    logic    is_auipc;
    alu_op_e alu_op;
    bjp_op_e bjp_op;
    mul_op_e mul_op;

    assign accept = dec_valid_i & ~hold_i;

    assign alu_op = alu_op_e'(op_i);
    assign bjp_op = bjp_op_e'(op_i[2:0]);
    assign mul_op = mul_op_e'(op_i[1:0]);

    // unconditional jumps also write pc+4 to rd
    assign is_jump  = (grp_i == GRP_BJP) && (bjp_op == BJP_JAL || bjp_op == BJP_JALR);
    assign is_auipc = (grp_i == GRP_ALU) && (alu_op == ALU_AUIPC);

    // ALU side
    assign alu_o.req = accept && (grp_i == GRP_ALU || is_jump);
    assign alu_o.op  = is_jump ? ALU_LINK : alu_op;
    assign alu_o.op1 = (is_jump || is_auipc) ? pc_i : rs1_data_i;
    assign alu_o.op2 = op2_imm_i ? imm_i : rs2_data_i;
    assign alu_o.rd  = rd_i;

    // branch compare always uses both registers
    assign bjp_o.req = accept && (grp_i == GRP_BJP);
    assign bjp_o.op  = bjp_op;
    assign bjp_o.op1 = rs1_data_i;
    assign bjp_o.op2 = rs2_data_i;
    assign bjp_o.rd  = rd_i;

    assign mul_o.req = accept && (grp_i == GRP_MUL);
    assign mul_o.op  = mul_op;
    assign mul_o.op1 = rs1_data_i;
    assign mul_o.op2 = rs2_data_i;
    assign mul_o.rd  = rd_i;

endmodule

`default_nettype wire

// ==== verilog/exu_alu.sv ====
// Single-cycle ALU; result is only meaningful while the request is high.
// Shifts use the low SHAMT_W bits of op2.
`timescale 1ns/1ps
`default_nettype none

module exu_alu (
    exu_op_if.unit              op_i,
    output exu_pkg::reg_data_t  result_o,
    output logic                load_o,
    output exu_pkg::reg_addr_t  rd_o
);
    import exu_pkg::*;

    logic [SHAMT_W-1:0] shamt;
    logic               lt_s;
    logic               lt_u;

    assign shamt = op_i.op2[SHAMT_W-1:0];
    assign lt_s  = $signed(op_i.op1) < $signed(op_i.op2);
    assign lt_u  = op_i.op1 < op_i.op2;

    always_comb begin
        unique case (op_i.op)
            ALU_ADD:   result_o = op_i.op1 + op_i.op2;
            ALU_SUB:   result_o = op_i.op1 - op_i.op2;
            ALU_AND:   result_o = op_i.op1 & op_i.op2;
            ALU_OR:    result_o = op_i.op1 | op_i.op2;
            ALU_XOR:   result_o = op_i.op1 ^ op_i.op2;
            ALU_SLL:   result_o = op_i.op1 << shamt;
            ALU_SRL:   result_o = op_i.op1 >> shamt;
            ALU_SRA:   result_o = reg_data_t'($signed(op_i.op1) >>> shamt);
            ALU_SLT:   result_o = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU:  result_o = {{(XLEN-1){1'b0}}, lt_u};
            // imm already holds the upper-immediate value
            ALU_LUI:   result_o = op_i.op2;
            ALU_AUIPC: result_o = op_i.op1 + op_i.op2;
            // op1 carries pc for jal/jalr
            ALU_LINK:  result_o = op_i.op1 + reg_data_t'(LINK_OFFSET);
            default:   result_o = '0;
        endcase
    end

    assign load_o = op_i.req;
    assign rd_o   = op_i.rd;

endmodule

`default_nettype wire

// ==== verilog/exu_bru.sv ====
// Resolves branches and jumps in the issue cycle; an interrupt overrides both outputs.
`timescale 1ns/1ps
`default_nettype none

module exu_bru (
    exu_op_if.unit              op_i,
    input  exu_pkg::inst_addr_t pc_i,
    input  exu_pkg::reg_data_t  imm_i,
    input  logic                int_assert_i,
    input  exu_pkg::inst_addr_t int_addr_i,
    output logic                jump_flag_o,
    output exu_pkg::inst_addr_t jump_addr_o
);
    import exu_pkg::*;

    logic       eq;
    logic       lt_s;
    logic       lt_u;
    logic       taken;
    logic       is_jalr;
    inst_addr_t base;
    inst_addr_t sum;

    assign eq   = op_i.op1 == op_i.op2;
    assign lt_s = $signed(op_i.op1) < $signed(op_i.op2);
    assign lt_u = op_i.op1 < op_i.op2;

    always_comb begin
        unique case (op_i.op)
            BJP_JAL, BJP_JALR: taken = 1'b1;
            BJP_BEQ:           taken = eq;
            BJP_BNE:           taken = ~eq;
            BJP_BLT:           taken = lt_s;
            BJP_BGE:           taken = ~lt_s;
            BJP_BLTU:          taken = lt_u;
            BJP_BGEU:          taken = ~lt_u;
            default:           taken = 1'b0;
        endcase
    end

    // one adder for both target forms, jalr clears bit 0
    assign is_jalr = op_i.op == BJP_JALR;
    assign base    = is_jalr ? op_i.op1 : pc_i;
    assign sum     = base + imm_i;

    assign jump_flag_o = int_assert_i | (op_i.req & taken);
    assign jump_addr_o = int_assert_i ? int_addr_i
                       : is_jalr ? {sum[XLEN-1:1], 1'b0} : sum;

endmodule

`default_nettype wire

// ==== verilog/exu_mul.sv ====
// Shift-add multiplier, one bit per cycle over MUL_ITERS steps on operand magnitudes.
// A new request is only expected while idle; an interrupt drops any multiply.
`timescale 1ns/1ps
`default_nettype none

module exu_mul (
    input  logic               clk,
    input  logic               rst_n_i,
    exu_op_if.unit             op_i,
    input  logic               int_assert_i,
    input  logic               port_full_i,
    output logic               busy_o,
    output logic               load_o,
    output exu_pkg::reg_data_t result_o,
    output exu_pkg::reg_addr_t rd_o
);
    import exu_pkg::*;

    logic [MUL_CNT_W-1:0] cnt;
    logic                 done;
    logic                 stepping;
    logic                 a_neg;
    logic                 b_neg;
    reg_data_t            mag_a;
    reg_data_t            mag_b;
    logic [2*XLEN-1:0]    acc;
    logic [2*XLEN-1:0]    mcand;
    reg_data_t            mplier;
    logic [2*XLEN-1:0]    prod;
    logic                 neg;
    logic                 hi_sel;

    // sign handling per op, mul takes the low word so it runs unsigned
    assign a_neg = (op_i.op == MUL_MULH || op_i.op == MUL_MULHSU) & op_i.op1[XLEN-1];
    assign b_neg = (op_i.op == MUL_MULH) & op_i.op2[XLEN-1];
    assign mag_a = a_neg ? -op_i.op1 : op_i.op1;
    assign mag_b = b_neg ? -op_i.op2 : op_i.op2;

    assign done     = cnt == MUL_CNT_W'(MUL_ITERS);
    assign stepping = busy_o & ~done;
    assign load_o   = busy_o & done & ~port_full_i & ~int_assert_i;

    // interrupt wins over both a running and a new multiply
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_o <= 1'b0;
            cnt    <= '0;
        end else if (int_assert_i) begin
            busy_o <= 1'b0;
            cnt    <= '0;
        end else if (op_i.req) begin
            busy_o <= 1'b1;
            cnt    <= '0;
        end else if (load_o) begin
            busy_o <= 1'b0;
        end else if (stepping) begin
            cnt <= cnt + MUL_CNT_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (op_i.req) begin
            acc    <= '0;
            mcand  <= {{XLEN{1'b0}}, mag_a};
            mplier <= mag_b;
            neg    <= a_neg ^ b_neg;
            hi_sel <= op_i.op != MUL_MUL;
            rd_o   <= op_i.rd;
        end else if (stepping) begin
            if (mplier[0])
                acc <= acc + mcand;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign prod     = neg ? -acc : acc;
    assign result_o = hi_sel ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];

endmodule

`default_nettype wire

// ==== verilog/exu_wb_port.sv ====
// One-entry write-back holding register; a load while full overwrites,
// so the producer must respect full_o.
`timescale 1ns/1ps
`default_nettype none

module exu_wb_port (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               load_i,
    input  exu_pkg::reg_data_t wdata_i,
    input  exu_pkg::reg_addr_t waddr_i,
    input  logic               ready_i,
    output logic               we_o,
    output exu_pkg::reg_addr_t waddr_o,
    output exu_pkg::reg_data_t wdata_o,
    output logic               full_o
);
    // a load at the same edge as a drain replaces the leaving entry
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i)
            we_o <= 1'b0;
        else if (load_i)
            we_o <= 1'b1;
        else if (ready_i)
            we_o <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            waddr_o <= waddr_i;
            wdata_o <= wdata_i;
        end
    end

    // occupied and not draining this cycle
    assign full_o = we_o & ~ready_i;

endmodule

`default_nettype wire

// ==== verilog/exu_top.sv ====
// Integer execute stage: ALU, branch unit and iterative multiplier.
// Upstream must keep its instruction steady while hold_flag_o is high.
`timescale 1ns/1ps
`default_nettype none

module exu_top (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                dec_valid_i,
    input  exu_pkg::grp_e       grp_i,
    input  exu_pkg::dec_op_t    op_i,
    input  logic                op2_imm_i,
    input  exu_pkg::inst_addr_t pc_i,
    input  exu_pkg::reg_data_t  imm_i,
    input  exu_pkg::reg_data_t  rs1_data_i,
    input  exu_pkg::reg_data_t  rs2_data_i,
    input  exu_pkg::reg_addr_t  rd_i,
    input  logic                int_assert_i,
    input  exu_pkg::inst_addr_t int_addr_i,
    input  logic                alu_wb_ready_i,
    input  logic                mul_wb_ready_i,
    output logic                alu_reg_we_o,
    output exu_pkg::reg_addr_t  alu_reg_waddr_o,
    output exu_pkg::reg_data_t  alu_reg_wdata_o,
    output logic                mul_reg_we_o,
    output exu_pkg::reg_addr_t  mul_reg_waddr_o,
    output exu_pkg::reg_data_t  mul_reg_wdata_o,
    output logic                hold_flag_o,
    output logic                jump_flag_o,
    output exu_pkg::inst_addr_t jump_addr_o
);
    import exu_pkg::*;

    exu_op_if #(.op_t(alu_op_e)) alu_if ();
    exu_op_if #(.op_t(bjp_op_e)) bjp_if ();
    exu_op_if #(.op_t(mul_op_e)) mul_if ();

    reg_data_t alu_result;
    reg_addr_t alu_rd;
    logic      alu_load;
    logic      alu_full;
    reg_data_t mul_result;
    reg_addr_t mul_rd;
    logic      mul_load;
    logic      mul_full;
    logic      mul_busy;

    // stall on a blocked ALU result or any multiply in flight
    assign hold_flag_o = alu_full | mul_busy;

    exu_dispatch u_dispatch (
        .dec_valid_i(dec_valid_i), .grp_i(grp_i), .op_i(op_i), .op2_imm_i(op2_imm_i),
        .pc_i(pc_i), .imm_i(imm_i), .rs1_data_i(rs1_data_i), .rs2_data_i(rs2_data_i),
        .rd_i(rd_i), .hold_i(hold_flag_o),
        .alu_o(alu_if.dispatch), .bjp_o(bjp_if.dispatch), .mul_o(mul_if.dispatch)
    );

    exu_alu u_alu (
        .op_i(alu_if.unit), .result_o(alu_result), .load_o(alu_load), .rd_o(alu_rd)
    );

    exu_bru u_bru (
        .op_i(bjp_if.unit), .pc_i(pc_i), .imm_i(imm_i), .int_assert_i(int_assert_i),
        .int_addr_i(int_addr_i), .jump_flag_o(jump_flag_o), .jump_addr_o(jump_addr_o)
    );

    exu_mul u_mul (
        .clk(clk), .rst_n_i(rst_n_i), .op_i(mul_if.unit), .int_assert_i(int_assert_i),
        .port_full_i(mul_full), .busy_o(mul_busy), .load_o(mul_load),
        .result_o(mul_result), .rd_o(mul_rd)
    );

    exu_wb_port u_alu_wb (
        .clk(clk), .rst_n_i(rst_n_i), .load_i(alu_load), .wdata_i(alu_result),
        .waddr_i(alu_rd), .ready_i(alu_wb_ready_i), .we_o(alu_reg_we_o),
        .waddr_o(alu_reg_waddr_o), .wdata_o(alu_reg_wdata_o), .full_o(alu_full)
    );

    exu_wb_port u_mul_wb (
        .clk(clk), .rst_n_i(rst_n_i), .load_i(mul_load), .wdata_i(mul_result),
        .waddr_i(mul_rd), .ready_i(mul_wb_ready_i), .we_o(mul_reg_we_o),
        .waddr_o(mul_reg_waddr_o), .wdata_o(mul_reg_wdata_o), .full_o(mul_full)
    );

endmodule

`default_nettype wire

// ==== sim/exu_assertions.sv ====
// Port-level checks bound into exu_top and sampled on the rising clock edge.
`timescale 1ns/1ps
`default_nettype none

module exu_assertions (
    input logic                clk,
    input logic                rst_n_i,
    input logic                int_assert_i,
    input exu_pkg::inst_addr_t int_addr_i,
    input logic                jump_flag_i,
    input exu_pkg::inst_addr_t jump_addr_i,
    input logic                hold_i,
    input logic                alu_we_i,
    input logic                alu_ready_i,
    input exu_pkg::reg_addr_t  alu_waddr_i,
    input exu_pkg::reg_data_t  alu_wdata_i,
    input logic                mul_we_i,
    input logic                mul_ready_i,
    input exu_pkg::reg_addr_t  mul_waddr_i,
    input exu_pkg::reg_data_t  mul_wdata_i
);

    // failed assertions so far
    int assert_errs = 0;

    reset_idle: assert property (@(posedge clk)
        $rose(rst_n_i) |-> !alu_we_i && !mul_we_i && !hold_i)
        else begin
            assert_errs++;
            $error("write enable or hold high right after reset");
        end

    int_redirect: assert property (@(posedge clk) disable iff (!rst_n_i)
        int_assert_i |-> jump_flag_i && jump_addr_i == int_addr_i)
        else begin
            assert_errs++;
            $error("interrupt did not redirect the jump address");
        end

    // an entry stays put until its ready is seen
    alu_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        alu_we_i && !alu_ready_i |=> alu_we_i && $stable(alu_wdata_i) && $stable(alu_waddr_i))
        else begin
            assert_errs++;
            $error("ALU write-back changed before ready");
        end

    mul_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        mul_we_i && !mul_ready_i |=> mul_we_i && $stable(mul_wdata_i) && $stable(mul_waddr_i))
        else begin
            assert_errs++;
            $error("multiply write-back changed before ready");
        end

endmodule

bind exu_top exu_assertions u_assertions (
    .clk(clk), .rst_n_i(rst_n_i), .int_assert_i(int_assert_i), .int_addr_i(int_addr_i),
    .jump_flag_i(jump_flag_o), .jump_addr_i(jump_addr_o), .hold_i(hold_flag_o),
    .alu_we_i(alu_reg_we_o), .alu_ready_i(alu_wb_ready_i),
    .alu_waddr_i(alu_reg_waddr_o), .alu_wdata_i(alu_reg_wdata_o),
    .mul_we_i(mul_reg_we_o), .mul_ready_i(mul_wb_ready_i),
    .mul_waddr_i(mul_reg_waddr_o), .mul_wdata_i(mul_reg_wdata_o)
);

`default_nettype wire

// ==== sim/tb_exu.sv ====
// Table-driven testbench for exu_top with random write-back ready,
// then interrupt redirect over a branch and a multiply cancel.
`timescale 1ns/1ps
`default_nettype none

module tb_exu;
    import exu_pkg::*;

    typedef struct packed {
        grp_e       grp;
        dec_op_t    op;
        logic       op2_imm;
        inst_addr_t pc;
        reg_data_t  imm;
        reg_data_t  rs1;
        reg_data_t  rs2;
        reg_addr_t  rd;
        reg_data_t  exp_data;
        logic       exp_jump;
        inst_addr_t exp_addr;
        grp_e       wb_port;
    } row_t;

    typedef struct packed {
        int        idx;
        reg_addr_t rd;
        reg_data_t data;
    } wb_t;

    localparam inst_addr_t INT_VEC = 32'h8000_0040;

    logic       clk;
    logic       rst_n_i;
    logic       dec_valid_i;
    grp_e       grp_i;
    dec_op_t    op_i;
    logic       op2_imm_i;
    inst_addr_t pc_i;
    reg_data_t  imm_i;
    reg_data_t  rs1_data_i;
    reg_data_t  rs2_data_i;
    reg_addr_t  rd_i;
    logic       int_assert_i;
    inst_addr_t int_addr_i;
    logic       alu_wb_ready_i;
    logic       mul_wb_ready_i;
    logic       alu_reg_we_o;
    reg_addr_t  alu_reg_waddr_o;
    reg_data_t  alu_reg_wdata_o;
    logic       mul_reg_we_o;
    reg_addr_t  mul_reg_waddr_o;
    reg_data_t  mul_reg_wdata_o;
    logic       hold_flag_o;
    logic       jump_flag_o;
    inst_addr_t jump_addr_o;

    row_t        rows[$];
    wb_t         alu_exp[$];
    wb_t         mul_exp[$];
    wb_t         alu_got;
    wb_t         mul_got;
    logic [1:0]  ready_pat[0:255];
    logic        rand_ready;
    int unsigned cycles;
    int unsigned cycle_limit;
    int          data_errs;
    int          jump_errs;
    int          hold_errs;
    int          order_errs;

    exu_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_data(input reg_addr_t got_rd, input reg_data_t got,
                              input reg_addr_t exp_rd, input reg_data_t exp, input string what);
        if (got_rd !== exp_rd || got !== exp) begin
            data_errs++;
            $display("FAILED %0t: %s wrote x%0d = %h, expected x%0d = %h",
                     $time, what, got_rd, got, exp_rd, exp);
        end
    endtask

    task automatic check_jump(input logic got_flag, input inst_addr_t got_addr,
                              input logic exp_flag, input inst_addr_t exp_addr, input string what);
        if (got_flag !== exp_flag || (exp_flag && got_addr !== exp_addr)) begin
            jump_errs++;
            $display("FAILED %0t: %s jump %b to %h, expected %b to %h",
                     $time, what, got_flag, got_addr, exp_flag, exp_addr);
        end
    endtask

    task automatic check_hold(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            hold_errs++;
            $display("FAILED %0t: %s hold %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic alu_row(input alu_op_e op, input logic op2_imm, input inst_addr_t pc,
                           input reg_data_t imm, input reg_data_t rs1, input reg_data_t rs2,
                           input reg_addr_t rd, input reg_data_t exp_data);
        rows.push_back('{GRP_ALU, dec_op_t'(op), op2_imm, pc, imm, rs1, rs2, rd, exp_data,
                         1'b0, 32'h0, GRP_ALU});
    endtask

    // jal and jalr also write pc+4
    task automatic bjp_row(input bjp_op_e op, input inst_addr_t pc, input reg_data_t imm,
                           input reg_data_t rs1, input reg_data_t rs2, input reg_addr_t rd,
                           input reg_data_t link, input logic taken, input inst_addr_t target);
        grp_e wb;
        wb = (op == BJP_JAL || op == BJP_JALR) ? GRP_ALU : GRP_NONE;
        rows.push_back('{GRP_BJP, dec_op_t'(op), 1'b1, pc, imm, rs1, rs2, rd, link,
                         taken, target, wb});
    endtask

    task automatic mul_row(input mul_op_e op, input reg_data_t rs1, input reg_data_t rs2,
                           input reg_addr_t rd, input reg_data_t exp_data);
        rows.push_back('{GRP_MUL, dec_op_t'(op), 1'b0, 32'h0, 32'h0, rs1, rs2, rd, exp_data,
                         1'b0, 32'h0, GRP_MUL});
    endtask

    task automatic build_table();
        alu_row(ALU_ADD,   1'b1, 32'h0,    32'h5,         32'h10,        32'h1234, 5'd1,  32'h15);
        alu_row(ALU_SUB,   1'b0, 32'h0,    32'h0,         32'h5,         32'h7,    5'd2,
                32'hFFFF_FFFE);
        alu_row(ALU_AND,   1'b0, 32'h0,    32'h0, 32'hF0F0_F0F0, 32'hFF00_FF00, 5'd3,
                32'hF000_F000);
        alu_row(ALU_OR,    1'b1, 32'h0,    32'hFF,        32'hF00,       32'h0,    5'd4,  32'hFFF);
        alu_row(ALU_XOR,   1'b0, 32'h0,    32'h0, 32'hAAAA_5555, 32'hFFFF_0000, 5'd5,
                32'h5555_5555);
        alu_row(ALU_SLL,   1'b1, 32'h0,    32'h4,         32'h3,         32'h0,    5'd6,  32'h30);
        // only the low five bits of op2 shift
        alu_row(ALU_SRL,   1'b0, 32'h0,    32'h0,  32'h8000_0000, 32'h21, 5'd7, 32'h4000_0000);
        alu_row(ALU_SRA,   1'b1, 32'h0,    32'h4,  32'h8000_0000, 32'h77, 5'd8, 32'hF800_0000);
        alu_row(ALU_SLT,   1'b0, 32'h0,    32'h0,  32'hFFFF_FFFF, 32'h1,  5'd9, 32'h1);
        alu_row(ALU_SLTU,  1'b0, 32'h0,    32'h0,  32'hFFFF_FFFF, 32'h1,  5'd10, 32'h0);
        alu_row(ALU_LUI,   1'b1, 32'h0,    32'h1234_5000, 32'h99, 32'h0,  5'd11, 32'h1234_5000);
        alu_row(ALU_AUIPC, 1'b1, 32'h1000, 32'h2000,      32'h99, 32'h0,  5'd12, 32'h3000);
        bjp_row(BJP_JAL,  32'h100, 32'h40,  32'h0, 32'h0, 5'd1,  32'h104, 1'b1, 32'h140);
        bjp_row(BJP_JALR, 32'h200, 32'h10,  32'h1001, 32'h0, 5'd13, 32'h204, 1'b1, 32'h1010);
        bjp_row(BJP_BEQ,  32'h300, 32'hFFFF_FFF0, 32'h55, 32'h55, 5'd0, 32'h0, 1'b1, 32'h2F0);
        bjp_row(BJP_BNE,  32'h310, 32'h20, 32'h7, 32'h7, 5'd0, 32'h0, 1'b0, 32'h0);
        bjp_row(BJP_BLT,  32'h400, 32'h8, 32'hFFFF_FFFE, 32'h1, 5'd0, 32'h0, 1'b1, 32'h408);
        bjp_row(BJP_BGE,  32'h410, 32'h8, 32'hFFFF_FFFE, 32'h1, 5'd0, 32'h0, 1'b0, 32'h0);
        bjp_row(BJP_BLTU, 32'h420, 32'h8, 32'hFFFF_FFFE, 32'h1, 5'd0, 32'h0, 1'b0, 32'h0);
        bjp_row(BJP_BGEU, 32'h500, 32'h20, 32'hFFFF_FFFE, 32'h1, 5'd0, 32'h0, 1'b1, 32'h520);
        mul_row(MUL_MUL,    32'h7,         32'h6,         5'd14, 32'h2A);
        mul_row(MUL_MUL,    32'hFFFF_FFFF, 32'hFFFF_FFFF, 5'd15, 32'h1);
        mul_row(MUL_MULH,   32'hFFFF_FFFF, 32'hFFFF_FFFF, 5'd16, 32'h0);
        mul_row(MUL_MULH,   32'h8000_0000, 32'h8000_0000, 5'd17, 32'h4000_0000);
        mul_row(MUL_MULH,   32'hFFFF_FFFE, 32'h3,         5'd18, 32'hFFFF_FFFF);
        mul_row(MUL_MULHSU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 5'd19, 32'hFFFF_FFFF);
        mul_row(MUL_MULHSU, 32'h2,         32'h8000_0000, 5'd20, 32'h1);
        mul_row(MUL_MULHU,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 5'd21, 32'hFFFF_FFFE);
        mul_row(MUL_MULHU,  32'h8000_0000, 32'h4,         5'd22, 32'h2);
        alu_row(ALU_ADD, 1'b0, 32'h0, 32'h0, 32'h7FFF_FFFF, 32'h1, 5'd23, 32'h8000_0000);
        alu_row(ALU_SRA, 1'b0, 32'h0, 32'h0, 32'h8000_00F0, 32'h4, 5'd24, 32'hF800_000F);
    endtask

    // starts on a rising edge and returns on the edge that accepts the entry
    task automatic issue(input int idx, input row_t r);
        string tag;
        wb_t   w;
        tag = $sformatf("entry %0d", idx);
        dec_valid_i <= 1'b1;
        grp_i       <= r.grp;
        op_i        <= r.op;
        op2_imm_i   <= r.op2_imm;
        pc_i        <= r.pc;
        imm_i       <= r.imm;
        rs1_data_i  <= r.rs1;
        rs2_data_i  <= r.rs2;
        rd_i        <= r.rd;
        @(negedge clk);
        while (hold_flag_o)
            @(negedge clk);
        check_jump(jump_flag_o, jump_addr_o, r.exp_jump, r.exp_addr, tag);
        w = '{idx, r.rd, r.exp_data};
        if (r.wb_port == GRP_ALU)
            alu_exp.push_back(w);
        if (r.wb_port == GRP_MUL)
            mul_exp.push_back(w);
        @(posedge clk);
        if (r.grp == GRP_MUL) begin
            @(negedge clk);
            check_hold(hold_flag_o, 1'b1, {tag, " multiply running"});
            @(posedge clk);
        end
    endtask

    task automatic drain();
        while (alu_exp.size() != 0 || mul_exp.size() != 0)
            @(negedge clk);
        @(posedge clk);
    endtask

    task automatic interrupt_checks();
        row_t br;
        row_t mr;
        // taken beq issued while the interrupt is up
        br = '{GRP_BJP, dec_op_t'(BJP_BEQ), 1'b1, 32'h600, 32'h40, 32'h9, 32'h9, 5'd0,
               32'h0, 1'b1, INT_VEC, GRP_NONE};
        // mulhu that never writes back
        mr = '{GRP_MUL, dec_op_t'(MUL_MULHU), 1'b0, 32'h0, 32'h0, 32'hFFFF_FFFF, 32'h3,
               5'd30, 32'h0, 1'b0, 32'h0, GRP_NONE};
        int_addr_i   <= INT_VEC;
        int_assert_i <= 1'b1;
        issue(rows.size(), br);
        int_assert_i <= 1'b0;
        issue(rows.size() + 1, mr);
        dec_valid_i <= 1'b0;
        repeat (4) @(posedge clk);
        int_assert_i <= 1'b1;
        @(negedge clk);
        check_jump(jump_flag_o, jump_addr_o, 1'b1, INT_VEC, "interrupt during multiply");
        @(posedge clk);
        int_assert_i <= 1'b0;
        @(negedge clk);
        check_hold(hold_flag_o, 1'b0, "cancelled multiply");
        // a late multiply write-back would show up in the monitor
        repeat (MUL_ITERS + 4) @(posedge clk);
    endtask

    // write-backs leave at the next rising edge and are checked in issue order
    always @(negedge clk) begin
        if (rst_n_i && alu_reg_we_o && alu_wb_ready_i) begin
            if (alu_exp.size() == 0) begin
                order_errs++;
                $display("unexpected ALU write-back to x%0d at %0t", alu_reg_waddr_o, $time);
            end else begin
                alu_got = alu_exp.pop_front();
                check_data(alu_reg_waddr_o, alu_reg_wdata_o, alu_got.rd, alu_got.data,
                           $sformatf("ALU port, entry %0d", alu_got.idx));
            end
        end
        if (rst_n_i && mul_reg_we_o && mul_wb_ready_i) begin
            if (mul_exp.size() == 0) begin
                order_errs++;
                $display("unexpected multiply write-back to x%0d at %0t", mul_reg_waddr_o, $time);
            end else begin
                mul_got = mul_exp.pop_front();
                check_data(mul_reg_waddr_o, mul_reg_wdata_o, mul_got.rd, mul_got.data,
                           $sformatf("multiply port, entry %0d", mul_got.idx));
            end
        end
    end

    always @(posedge clk) begin
        if (rand_ready) begin
            alu_wb_ready_i <= ready_pat[cycles[7:0]][0];
            mul_wb_ready_i <= ready_pat[cycles[7:0]][1];
        end else begin
            alu_wb_ready_i <= 1'b1;
            mul_wb_ready_i <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(67126));
        // ready low about one cycle in three
        for (int i = 0; i < 256; i++)
            ready_pat[i] = {($urandom % 3) != 0, ($urandom % 3) != 0};
        rst_n_i        = 1'b0;
        dec_valid_i    = 1'b0;
        grp_i          = GRP_NONE;
        op_i           = '0;
        op2_imm_i      = 1'b0;
        pc_i           = '0;
        imm_i          = '0;
        rs1_data_i     = '0;
        rs2_data_i     = '0;
        rd_i           = '0;
        int_assert_i   = 1'b0;
        int_addr_i     = '0;
        alu_wb_ready_i = 1'b1;
        mul_wb_ready_i = 1'b1;
        rand_ready     = 1'b0;
        cycles         = 0;
        data_errs      = 0;
        jump_errs      = 0;
        hold_errs      = 0;
        order_errs     = 0;
        build_table();
        // two extra entries for the interrupt checks
        cycle_limit = 16 + (rows.size() + 2) * (MUL_ITERS + 10);
        repeat (16) @(posedge clk);
        rst_n_i    <= 1'b1;
        rand_ready <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < rows.size(); i++)
            issue(i, rows[i]);
        dec_valid_i <= 1'b0;
        rand_ready  <= 1'b0;
        drain();
        interrupt_checks();
        $display("errors: data %0d, jump %0d, hold %0d, write-back order %0d, assertion %0d",
                 data_errs, jump_errs, hold_errs, order_errs, DUT.u_assertions.assert_errs);
        if (data_errs + jump_errs + hold_errs + order_errs +
            DUT.u_assertions.assert_errs == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
verilog/exu_pkg.sv
verilog/exu_op_if.sv
verilog/exu_dispatch.sv
verilog/exu_alu.sv
verilog/exu_bru.sv
verilog/exu_mul.sv
verilog/exu_wb_port.sv
verilog/exu_top.sv
sim/exu_assertions.sv
sim/tb_exu.sv
